// ==== common/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Widths
`define NIBBLE_W 4
`define ADDR_W   12
`define INSTR_W  12
`define SP_W     8

// First instruction after reset
`define RESET_PC 12'h100

// Opcode bases
`define OP_LD_RI 12'hE00   // LD r,i   r in [5:4], i in [3:0]
`define OP_LD_X  12'hB00   // LD X,e
`define OP_LD_Y  12'h800   // LD Y,e
`define OP_PUSH  12'hFC0   // PUSH sel
`define OP_POP   12'hFD0   // POP sel

`endif

// ==== common/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

    typedef logic [`NIBBLE_W-1:0] nibble_t;
    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`INSTR_W-1:0]  instr_t;
    typedef logic [`SP_W-1:0]     sp_t;

    // Five clocks per instruction
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        READ,
        EXECUTE,
        WRITE
    } phase_t;

    typedef enum logic [2:0] {
        NOP,
        LD_IMM,
        LD_XE,
        LD_YE,
        PUSH,
        POP
    } op_t;

    // Same order as the low nibble of PUSH and POP
    typedef enum logic [3:0] {
        SEL_A,
        SEL_B,
        SEL_MX,
        SEL_MY,
        SEL_XP,
        SEL_XH,
        SEL_XL,
        SEL_YP,
        SEL_YH,
        SEL_YL,
        SEL_F
    } stack_sel_t;

    typedef struct packed {
        op_t        op;
        stack_sel_t sel;
        logic [7:0] imm;
        logic       ram_rd;   // Needs a RAM read in READ
        logic       ram_wr;   // Needs a RAM write in WRITE
    } decoded_t;

    typedef struct packed {
        addr_t   addr;
        nibble_t wdata;
        logic    rd;
        logic    wr;
    } mem_req_t;

endpackage

// ==== core/instr_decoder.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_decoder (
    input  core_pkg::instr_t   ir,
    output core_pkg::decoded_t dec
);
    import core_pkg::*;

    logic sel_valid;
    logic sel_is_mem;

    assign sel_valid  = (ir[3:0] <= 4'(SEL_F));
    assign sel_is_mem = (ir[3:1] == 3'b001);   // MX or MY

    always_comb begin
        dec        = '0;
        dec.op     = NOP;
        dec.sel    = SEL_A;
        dec.imm    = ir[7:0];

        if ((ir & 12'hFC0) == `OP_LD_RI) begin
            dec.op     = LD_IMM;
            dec.sel    = stack_sel_t'({2'b00, ir[5:4]});
            dec.ram_wr = ir[5];   // r = MX or MY
        end else if ((ir & 12'hF00) == `OP_LD_X) begin
            dec.op = LD_XE;
        end else if ((ir & 12'hF00) == `OP_LD_Y) begin
            dec.op = LD_YE;
        end else if ((ir & 12'hFF0) == `OP_PUSH && sel_valid) begin
            dec.op     = PUSH;
            dec.sel    = stack_sel_t'(ir[3:0]);
            dec.ram_rd = sel_is_mem;   // Fetch M(X) or M(Y) first
            dec.ram_wr = 1'b1;
        end else if ((ir & 12'hFF0) == `OP_POP && sel_valid) begin
            dec.op     = POP;
            dec.sel    = stack_sel_t'(ir[3:0]);
            dec.ram_rd = 1'b1;
            dec.ram_wr = sel_is_mem;   // Popped nibble goes back to RAM
        end
    end

endmodule

// ==== core/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::phase_t   phase,
    input  core_pkg::decoded_t dec,
    input  core_pkg::nibble_t  pop_data,
    output core_pkg::addr_t    x,
    output core_pkg::addr_t    y,
    output core_pkg::sp_t      sp,
    output core_pkg::nibble_t  stack_out
);
    import core_pkg::*;

    // Bit 0 is carry, bit 3 is interrupt
    typedef struct packed {
        logic interrupt;
        logic decimal;
        logic zero;
        logic carry;
    } flags_t;

    nibble_t a;
    nibble_t b;
    flags_t  f;

    always_ff @(posedge clk) begin
        if (reset) begin
            a  <= '0;
            b  <= '0;
            x  <= '0;
            y  <= '0;
            sp <= '0;
            f  <= '0;
        end else if (phase == EXECUTE) begin
            case (dec.op)
                LD_IMM: begin
                    case (dec.sel)
                        SEL_A:   a <= dec.imm[3:0];
                        SEL_B:   b <= dec.imm[3:0];
                        default: ;   // MX and MY are written by the sequencer
                    endcase
                end
                LD_XE: x[7:0] <= dec.imm;   // XP kept
                LD_YE: y[7:0] <= dec.imm;
                PUSH:  sp <= sp - 1'b1;
                POP: begin
                    sp <= sp + 1'b1;
                    case (dec.sel)
                        SEL_A:   a       <= pop_data;
                        SEL_B:   b       <= pop_data;
                        SEL_XP:  x[11:8] <= pop_data;
                        SEL_XH:  x[7:4]  <= pop_data;
                        SEL_XL:  x[3:0]  <= pop_data;
                        SEL_YP:  y[11:8] <= pop_data;
                        SEL_YH:  y[7:4]  <= pop_data;
                        SEL_YL:  y[3:0]  <= pop_data;
                        SEL_F:   f       <= flags_t'(pop_data);
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Value pushed for the register selectors
    always_comb begin
        case (dec.sel)
            SEL_A:   stack_out = a;
            SEL_B:   stack_out = b;
            SEL_XP:  stack_out = x[11:8];
            SEL_XH:  stack_out = x[7:4];
            SEL_XL:  stack_out = x[3:0];
            SEL_YP:  stack_out = y[11:8];
            SEL_YH:  stack_out = y[7:4];
            SEL_YL:  stack_out = y[3:0];
            SEL_F:   stack_out = nibble_t'(f);
            default: stack_out = '0;
        endcase
    end

    a_sp_in_execute: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && $changed(sp)) |-> $past(phase) == EXECUTE)
        else $error("sp changed outside EXECUTE");

endmodule

// ==== core/core_sequencer.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::decoded_t dec,
    input  core_pkg::addr_t    x,
    input  core_pkg::addr_t    y,
    input  core_pkg::sp_t      sp,
    input  core_pkg::nibble_t  stack_out,
    input  core_pkg::instr_t   rom_data,
    input  core_pkg::nibble_t  ram_rdata,
    output core_pkg::phase_t   phase,
    output core_pkg::instr_t   ir,
    output core_pkg::nibble_t  pop_data,
    output core_pkg::addr_t    rom_addr,
    output core_pkg::mem_req_t ram_req
);
    import core_pkg::*;

    addr_t   pc;
    nibble_t rd_q;         // RAM nibble held for WRITE
    addr_t   stack_addr;   // Stack lives in page 0
    addr_t   mem_addr;
    logic    sel_is_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= FETCH;
        end else begin
            case (phase)
                FETCH:   phase <= DECODE;
                DECODE:  phase <= READ;
                READ:    phase <= EXECUTE;
                EXECUTE: phase <= WRITE;
                default: phase <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
            ir <= '0;   // Decodes as NOP
        end else begin
            if (phase == DECODE) begin
                ir <= rom_data;
            end
            if (phase == EXECUTE) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase == EXECUTE) begin
            rd_q <= ram_rdata;
        end
    end

    assign rom_addr   = pc;
    assign pop_data   = (phase == EXECUTE) ? ram_rdata : rd_q;
    assign stack_addr = {{(`ADDR_W - `SP_W){1'b0}}, sp};
    assign sel_is_mem = (dec.sel == SEL_MX) || (dec.sel == SEL_MY);
    assign mem_addr   = (dec.sel == SEL_MY) ? y : x;

    always_comb begin
        ram_req = '0;
        if (phase == READ && dec.ram_rd) begin
            ram_req.rd   = 1'b1;
            ram_req.addr = (dec.op == POP) ? stack_addr : mem_addr;
        end
        if (phase == WRITE && dec.ram_wr) begin
            ram_req.wr = 1'b1;
            case (dec.op)
                PUSH: begin
                    ram_req.addr  = stack_addr;   // SP already decremented
                    ram_req.wdata = sel_is_mem ? rd_q : stack_out;
                end
                POP: begin
                    ram_req.addr  = mem_addr;
                    ram_req.wdata = rd_q;
                end
                default: begin
                    ram_req.addr  = mem_addr;   // LD MX,i or LD MY,i
                    ram_req.wdata = dec.imm[3:0];
                end
            endcase
        end
    end

    a_ram_rd_wr: assert property (@(posedge clk) disable iff (reset)
        !(ram_req.rd && ram_req.wr) && (!ram_req.wr || phase == WRITE))
        else $error("ram_req rd/wr overlap or write outside WRITE");

    // A POP write must carry a nibble read two cycles before
    a_pop_after_read: assert property (@(posedge clk) disable iff (reset)
        (ram_req.wr && dec.op == POP) |-> $past(ram_req.rd, 2))
        else $error("POP write without a preceding stack read");

endmodule

// ==== design/nibble_cpu_top.sv ====
`timescale 1ns/1ps

module nibble_cpu_top (
    input  logic               clk,
    input  logic               reset,
    output core_pkg::addr_t    rom_addr,
    input  core_pkg::instr_t   rom_data,
    output core_pkg::mem_req_t ram_req,
    input  core_pkg::nibble_t  ram_rdata
);
    import core_pkg::*;

    phase_t   phase;
    instr_t   ir;
    decoded_t dec;
    addr_t    x;
    addr_t    y;
    sp_t      sp;
    nibble_t  stack_out;
    nibble_t  pop_data;

    core_sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec),
        .x         (x),
        .y         (y),
        .sp        (sp),
        .stack_out (stack_out),
        .rom_data  (rom_data),
        .ram_rdata (ram_rdata),
        .phase     (phase),
        .ir        (ir),
        .pop_data  (pop_data),
        .rom_addr  (rom_addr),
        .ram_req   (ram_req)
    );

    instr_decoder u_decoder (
        .ir  (ir),
        .dec (dec)
    );

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .dec       (dec),
        .pop_data  (pop_data),
        .x         (x),
        .y         (y),
        .sp        (sp),
        .stack_out (stack_out)
    );

endmodule

// ==== bench/nibble_cpu_checker.sv ====
`timescale 1ns/1ps

module nibble_cpu_checker (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::addr_t    rom_addr,
    input  core_pkg::mem_req_t ram_req,
    input  core_pkg::mem_req_t exp_writes [0:63],
    input  int                 exp_count,
    input  logic               test_end,
    output int                 write_errors,
    output int                 fetch_errors
);
    import core_pkg::*;

    int    write_idx;
    int    held;       // Cycles the current rom_addr has been up
    addr_t last_rom;
    logic  reset_q;

    initial begin
        write_errors = 0;
        fetch_errors = 0;
    end

    always @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            write_idx <= 0;
            held      <= 1;   // First cycle out of reset is FETCH
            last_rom  <= rom_addr;
        end else begin
            held <= held + 1;
            if (reset_q && rom_addr !== 12'h100) begin
                $display("FAIL t=%0t rom_addr expected 100 got %h", $time, rom_addr);
                fetch_errors++;
            end
            if (rom_addr != last_rom) begin
                if (rom_addr !== last_rom + 12'h1) begin
                    $display("FAIL t=%0t rom_addr expected %h got %h",
                             $time, last_rom + 12'h1, rom_addr);
                    fetch_errors++;
                end
                if (held != 5) begin
                    $display("t=%0t rom_addr advanced after %0d cycles instead of 5",
                             $time, held);
                    fetch_errors++;
                end
                held     <= 1;
                last_rom <= rom_addr;
            end
            if (ram_req.wr) begin
                if (write_idx >= exp_count) begin
                    $display("t=%0t unexpected RAM write, ram_req is %h", $time, ram_req);
                    write_errors++;
                end else if (ram_req !== exp_writes[write_idx]) begin
                    $display("FAIL t=%0t ram_req expected %h got %h",
                             $time, exp_writes[write_idx], ram_req);
                    write_errors++;
                end
                write_idx <= write_idx + 1;
            end
            if (test_end && write_idx < exp_count) begin
                $display("t=%0t %0d of %0d expected RAM writes never happened",
                         $time, exp_count - write_idx, exp_count);
                write_errors++;
            end
        end
    end

endmodule

// ==== bench/nibble_cpu_tb.sv ====
`timescale 1ns/1ps

module nibble_cpu_tb;
    import core_pkg::*;

    localparam int WAIT_LIMIT = 500;

    logic     clk;
    logic     reset;
    addr_t    rom_addr;
    instr_t   rom_data = 12'hFFB;
    mem_req_t ram_req;
    nibble_t  ram_rdata = '0;
    logic     test_end;
    instr_t   rom [0:4095];
    nibble_t  ram [0:4095];
    mem_req_t exp_writes [0:63];
    int       exp_count;
    int       prog_len;
    int       file_errors;
    int       timeouts;
    int       write_errors;
    int       fetch_errors;

    nibble_cpu_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    nibble_cpu_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .rom_addr     (rom_addr),
        .ram_req      (ram_req),
        .exp_writes   (exp_writes),
        .exp_count    (exp_count),
        .test_end     (test_end),
        .write_errors (write_errors),
        .fetch_errors (fetch_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ROM and RAM both answer one cycle after the request
    always @(posedge clk) begin
        rom_data <= rom[rom_addr];
    end

    always @(posedge clk) begin
        if (ram_req.rd) begin
            ram_rdata <= ram[ram_req.addr];
        end
        if (ram_req.wr && !reset) begin
            ram[ram_req.addr] <= ram_req.wdata;
        end
    end

    task automatic start_block();
        int i;
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        for (i = 0; i < 4096; i++) begin
            rom[i] = 12'hFFB;
            ram[i] = nibble_t'(i[11:8] ^ i[7:4] ^ i[3:0]) ^ 4'h5;
        end
        exp_count = 0;
        prog_len  = 0;
    endtask

    task automatic run_block();
        int    cycles;
        addr_t last_addr;
        last_addr = addr_t'(12'h100 + prog_len + 2);   // Program plus two NOPs
        repeat (7) @(posedge clk);
        reset  <= 1'b0;
        cycles = 0;
        while (rom_addr != last_addr && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rom_addr != last_addr) begin
            $display("Timeout waiting for rom_addr to reach %h", last_addr);
            timeouts++;
        end else begin
            test_end <= 1'b1;
            @(posedge clk);
            test_end <= 1'b0;
        end
    endtask

    initial begin
        int              fd;
        int              code;
        int              a;
        int              d;
        logic [8*8-1:0]  tok;
        logic [8*32-1:0] name;
        logic [8*128-1:0] rest;
        reset       = 1'b1;
        test_end    = 1'b0;
        file_errors = 0;
        timeouts    = 0;
        fd = $fopen("bench/nibble_cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/nibble_cpu_tests.txt");
            file_errors++;
        end
        while (fd != 0 && timeouts == 0 && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "T") begin
                code = $fscanf(fd, "%s", name);
                $display("Running %0s", name);
                start_block();
            end else if (tok == "R") begin
                code = $fscanf(fd, "%h %h", a, d);
                if (code != 2) begin
                    $display("Malformed R line in the test file");
                    file_errors++;
                end
                ram[a] = nibble_t'(d);
            end else if (tok == "P") begin
                code = $fscanf(fd, "%h", d);
                if (code != 1) begin
                    $display("Malformed P line in the test file");
                    file_errors++;
                end
                rom[12'h100 + prog_len] = instr_t'(d);
                prog_len++;
            end else if (tok == "W") begin
                code = $fscanf(fd, "%h %h", a, d);
                if (code != 2) begin
                    $display("Malformed W line in the test file");
                    file_errors++;
                end
                exp_writes[exp_count] = {addr_t'(a), nibble_t'(d), 2'b01};   // Write only
                exp_count++;
            end else if (tok == "E") begin
                run_block();
            end else begin
                $display("Unknown line type %0s in the test file", tok);
                file_errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        @(negedge clk);
        $display("errors: write %0d, fetch %0d, file %0d, timeout %0d",
                 write_errors, fetch_errors, file_errors, timeouts);
        if (write_errors + fetch_errors + file_errors + timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== nibble_cpu_top.f ====
+incdir+common
common/core_pkg.sv
core/instr_decoder.sv
core/register_file.sv
core/core_sequencer.sv
design/nibble_cpu_top.sv
bench/nibble_cpu_checker.sv
bench/nibble_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module nibble_cpu_tb \
    -f nibble_cpu_top.f -o nibble_cpu_sim || exit 1
out=$(./obj_dir/nibble_cpu_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== bench/nibble_cpu_tests.txt ====
# T name | R addr data (RAM preload) | P word (ROM from 100) | W addr data (expected write) | E
T reset_idle
P FFB
E
T push_a_b
P E07
P E1C
P FC0
P FC1
W 0FF 7
W 0FE C
E
T pop_push_a_b
R 000 9
R 001 6
P FD0
P FD1
P FC1
P FC0
W 001 6
W 000 9
E
T pop_mx_my
R 000 5
R 001 A
P B34
P FD2
P 856
P FD3
W 034 5
W 056 A
E
T x_nibbles
R 000 2
P B9C
P FD4
P FC5
P FC6
P FC4
W 000 9
W 0FF C
W 0FE 2
E
T y_nibbles
R 000 7
P 84E
P FD7
P FC8
P FC9
P FC7
W 000 4
W 0FF E
W 0FE 7
E
T flags_and_nop
R 000 A
P FDA
P FCA
P FCB
W 000 A
E
